// File: build.sh
#!/usr/bin/env bash
# Compile and run the KS10 bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --Mdir obj_dir \
   --top-module ks10BusTb -f ks10Bus.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/Vks10BusTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
   exit 0
else
   echo "Pass message not found in simulation output"
   exit 1
fi

// File: design/ks10Arbiter.sv
// KS10 bus arbiter
`timescale 1ns/1ns

module ks10Arbiter
   import ks10Pkg::*;
(
   input  logic        clk,
   input  logic        arstN,
   // CPU master
   input  logic        cpuReq,
   output logic        cpuAck,
   input  ks10Addr     cpuAddr,
   input  ks10Word     cpuWrData,
   output ks10Word     cpuRdData,
   // Console master
   input  logic        cslReq,
   output logic        cslAck,
   input  ks10Addr     cslAddr,
   input  ks10Word     cslWrData,
   output ks10Word     cslRdData,
   // Unibus master
   input  logic        ubaReq,
   output logic        ubaAck,
   input  ks10Addr     ubaAddr,
   input  ks10Word     ubaWrData,
   output ks10Word     ubaRdData,
   // Console as a target
   output logic        cslReqOut,
   input  logic        cslAckIn,
   input  ks10Word     cslTgtData,
   // Shared address and data
   output ks10Addr     arbAddr,
   output ks10Word     arbWrData,
   // Targets
   ks10BusIf.initiator memBus,
   ks10BusIf.initiator ioBus
);

   arbState state;
   arbState stateNext;
   ks10Addr gntAddr;      // Address of granted master
   ks10Word gntWrData;
   ioDev    gntDev;
   logic    busy;
   logic    selMem;
   logic    selCsl;
   logic    selIo;
   logic    tgtAck;       // Ack of selected target
   ks10Word tgtData;

   //////////////////////////////
   // Grant FSM
   //////////////////////////////

   // Console first, then Unibus, then CPU
   always_comb
   begin
      stateNext = state;
      unique case (state)
         idle:
         begin
            if (cslReq)
               stateNext = grantCsl;
            else if (ubaReq)
               stateNext = grantUba;
            else if (cpuReq)
               stateNext = grantCpu;
         end
         grantCsl: if (cslAck) stateNext = idle;   // Held until its ack
         grantUba: if (ubaAck) stateNext = idle;
         grantCpu: if (cpuAck) stateNext = idle;
         default:  stateNext = idle;
      endcase
   end

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         state <= idle;
      else
         state <= stateNext;
   end

   //////////////////////////////
   // Address mux and decode
   //////////////////////////////

   always_comb
   begin
      unique case (state)
         grantCsl:
         begin
            gntAddr   = cslAddr;
            gntWrData = cslWrData;
         end
         grantUba:
         begin
            gntAddr   = ubaAddr;
            gntWrData = ubaWrData;
         end
         grantCpu:
         begin
            gntAddr   = cpuAddr;
            gntWrData = cpuWrData;
         end
         default:
         begin
            gntAddr   = '0;          // Bus quiet when idle
            gntWrData = '0;
         end
      endcase
   end

   assign busy   = (state != idle);
   assign gntDev = gntAddr[ioDevMsb:ioDevLsb];
   assign selMem = ~gntAddr[addrIoBit];
   assign selCsl = gntAddr[addrIoBit] & (gntDev == cslDev);
   assign selIo  = gntAddr[addrIoBit] & (gntDev != cslDev);

   // Only the chosen target sees a request
   assign memBus.req    = busy & selMem;
   assign ioBus.req     = busy & selIo;
   assign cslReqOut     = busy & selCsl & (state != grantCsl);   // Never to itself

   assign memBus.addr   = gntAddr;
   assign memBus.wrData = gntWrData;
   assign ioBus.addr    = gntAddr;
   assign ioBus.wrData  = gntWrData;
   assign arbAddr       = gntAddr;
   assign arbWrData     = gntWrData;

   //////////////////////////////
   // Reply mux
   //////////////////////////////

   always_comb
   begin
      if (selMem)
      begin
         tgtAck  = memBus.ack;
         tgtData = memBus.rdData;
      end
      else if (selIo)
      begin
         tgtAck  = ioBus.ack;
         tgtData = ioBus.rdData;
      end
      else
      begin
         tgtAck  = cslAckIn;             // Console answers at its own pace
         tgtData = cslTgtData;
      end
   end

   // Reply goes to the granted master alone
   assign cslAck    = (state == grantCsl) & tgtAck;
   assign ubaAck    = (state == grantUba) & tgtAck;
   assign cpuAck    = (state == grantCpu) & tgtAck;
   assign cslRdData = (state == grantCsl) ? tgtData : '0;
   assign ubaRdData = (state == grantUba) ? tgtData : '0;
   assign cpuRdData = (state == grantCpu) ? tgtData : '0;

endmodule

// File: design/ks10Bus.sv
// KS10 memory bus top level
`timescale 1ns/1ns

module ks10Bus
   import ks10Pkg::*;
(
   input  logic    clk,
   input  logic    arstN,
   // CPU master
   input  logic    cpuReq,
   output logic    cpuAck,
   input  ks10Addr cpuAddr,
   input  ks10Word cpuWrData,
   output ks10Word cpuRdData,
   // Console master
   input  logic    cslReq,
   output logic    cslAck,
   input  ks10Addr cslAddr,
   input  ks10Word cslWrData,
   output ks10Word cslRdData,
   // Unibus master
   input  logic    ubaReq,
   output logic    ubaAck,
   input  ks10Addr ubaAddr,
   input  ks10Word ubaWrData,
   output ks10Word ubaRdData,
   // Console target
   output logic    cslReqOut,
   input  logic    cslAckIn,
   input  ks10Word cslTgtData,
   // Shared bus
   output ks10Addr arbAddr,
   output ks10Word arbWrData
);

   ks10BusIf memBus ();   // Arbiter to memory
   ks10BusIf ioBus ();    // Arbiter to I/O registers

   ks10Arbiter arbiter (
      .clk        (clk),
      .arstN      (arstN),
      .cpuReq     (cpuReq),
      .cpuAck     (cpuAck),
      .cpuAddr    (cpuAddr),
      .cpuWrData  (cpuWrData),
      .cpuRdData  (cpuRdData),
      .cslReq     (cslReq),
      .cslAck     (cslAck),
      .cslAddr    (cslAddr),
      .cslWrData  (cslWrData),
      .cslRdData  (cslRdData),
      .ubaReq     (ubaReq),
      .ubaAck     (ubaAck),
      .ubaAddr    (ubaAddr),
      .ubaWrData  (ubaWrData),
      .ubaRdData  (ubaRdData),
      .cslReqOut  (cslReqOut),
      .cslAckIn   (cslAckIn),
      .cslTgtData (cslTgtData),
      .arbAddr    (arbAddr),
      .arbWrData  (arbWrData),
      .memBus     (memBus.initiator),
      .ioBus      (ioBus.initiator)
   );

   // Targets serve side by side
   ks10Memory memory (
      .clk   (clk),
      .arstN (arstN),
      .bus   (memBus.target)
   );

   ks10UbaRegs ubaRegs (
      .clk   (clk),
      .arstN (arstN),
      .bus   (ioBus.target)
   );

endmodule

// File: design/ks10BusIf.sv
// KS10 target bus
`timescale 1ns/1ns

interface ks10BusIf
   import ks10Pkg::*;
();

   logic    req;       // Level request from arbiter
   logic    ack;       // One-cycle acknowledge
   ks10Addr addr;      // Address with flags
   ks10Word wrData;    // Write data
   ks10Word rdData;    // Read data, valid with ack

   // Arbiter side
   modport initiator (
      output req,
      output addr,
      output wrData,
      input  ack,
      input  rdData
   );

   // Memory or register bank side
   modport target (
      input  req,
      input  addr,
      input  wrData,
      output ack,
      output rdData
   );

endinterface

// File: design/ks10Memory.sv
// KS10 main memory
`timescale 1ns/1ns

module ks10Memory
   import ks10Pkg::*;
(
   input  logic     clk,
   input  logic     arstN,
   ks10BusIf.target bus
);

   ks10Word mem [0:memWords-1];   // 1K words
   ks10Word rdReg;                // Registered read word
   memIdx   idx;
   logic    wrCycle;
   logic    accept;
   logic    ready;                // Ack cycle
   logic    readyHold;            // Blanking cycle after ack

   //////////////////////////////
   // Handshake
   //////////////////////////////

   assign idx     = bus.addr[wordBits-memAddrBits +: memAddrBits];   // Low address bits
   assign wrCycle = bus.addr[addrWriteBit];

   // Held request is served once
   assign accept = bus.req & ~ready & ~readyHold;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         ready     <= 1'b0;
         readyHold <= 1'b0;
      end
      else
      begin
         ready     <= accept;        // Ack one cycle after accept
         readyHold <= ready;         // Then ignore req once
      end
   end

   //////////////////////////////
   // Storage
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (accept & wrCycle)
         mem[idx] <= bus.wrData;
   end

   // Read word held for the ack cycle
   always_ff @(posedge clk)
   begin
      if (accept & ~wrCycle)
         rdReg <= mem[idx];
   end

   assign bus.ack    = ready;
   assign bus.rdData = rdReg;

endmodule

// File: design/ks10Pkg.sv
// KS10 bus shared definitions
package ks10Pkg;

   //////////////////////////////
   // Words and addresses
   //////////////////////////////

   localparam int wordBits = 36;               // PDP-10 word width

   typedef logic [0:wordBits-1] ks10Word;      // Bit 0 is the MSB, as on the KS10
   typedef logic [0:wordBits-1] ks10Addr;      // Flags in 0:13, address in 14:35

   // Address flags
   localparam int addrWriteBit = 5;            // Write cycle
   localparam int addrIoBit    = 10;           // I/O space cycle

   //////////////////////////////
   // I/O address fields
   //////////////////////////////

   localparam int ioDevMsb  = 14;              // Device number field
   localparam int ioDevLsb  = 17;
   localparam int ioDevBits = ioDevLsb - ioDevMsb + 1;

   typedef logic [ioDevBits-1:0] ioDev;

   localparam ioDev cslDev = '0;               // Device 0 is the console

   // Memory index
   localparam int memAddrBits = 10;
   localparam int memWords    = 1 << memAddrBits;
   typedef logic [memAddrBits-1:0] memIdx;

   // I/O register index
   localparam int ioRegBits  = 4;
   localparam int ioRegCount = 1 << ioRegBits;
   typedef logic [ioRegBits-1:0] ioIdx;

   // Arbiter grant FSM
   typedef enum logic [1:0] {idle, grantCsl, grantUba, grantCpu} arbState;

endpackage

// File: design/ks10UbaRegs.sv
// KS10 Unibus I/O registers
`timescale 1ns/1ns

module ks10UbaRegs
   import ks10Pkg::*;
(
   input  logic     clk,
   input  logic     arstN,
   ks10BusIf.target bus
);

   ks10Word regs [0:ioRegCount-1];   // Sixteen device registers
   ks10Word rdReg;
   ioIdx    idx;
   logic    wrCycle;
   logic    accept;
   logic    ready;
   logic    readyHold;

   //////////////////////////////
   // Handshake
   //////////////////////////////

   assign idx     = bus.addr[wordBits-ioRegBits +: ioRegBits];   // Register number
   assign wrCycle = bus.addr[addrWriteBit];
   assign accept  = bus.req & ~ready & ~readyHold;

   // Same ack and blanking rule as memory
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         ready     <= 1'b0;
         readyHold <= 1'b0;
      end
      else
      begin
         ready     <= accept;
         readyHold <= ready;
      end
   end

   //////////////////////////////
   // Register file
   //////////////////////////////

   // Registers come up clear
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         regs <= '{default: '0};
      else if (accept & wrCycle)
         regs[idx] <= bus.wrData;
   end

   always_ff @(posedge clk)
   begin
      if (accept & ~wrCycle)
         rdReg <= regs[idx];          // Sampled at accept
   end

   assign bus.ack    = ready;
   assign bus.rdData = rdReg;

endmodule

// File: ks10Bus.f
design/ks10Pkg.sv
design/ks10BusIf.sv
design/ks10Arbiter.sv
design/ks10Memory.sv
design/ks10UbaRegs.sv
design/ks10Bus.sv
test/tbClock.sv
test/ks10Arbiter_assert.sv
test/ks10BusTb.sv

// File: test/ks10Arbiter_assert.sv
// Arbiter bus assertions
`timescale 1ns/1ns

module ks10ArbiterAssert
   import ks10Pkg::*;
(
   input logic    clk,
   input logic    arstN,
   input logic    cpuReq,
   input logic    cslReq,
   input logic    ubaReq,
   input logic    cpuAck,
   input logic    cslAck,
   input logic    ubaAck,
   input logic    cslReqOut,
   input arbState state
);

   //////////////////////////////
   // Master replies
   //////////////////////////////

   // One master served at a time
   oneAck: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0({cpuAck, cslAck, ubaAck}))
      else $error("More than one master acknowledge high");

   cpuAckReq: assert property (@(posedge clk) disable iff (!arstN)
      cpuAck |-> cpuReq)
      else $error("CPU acknowledged without a request");

   cslAckReq: assert property (@(posedge clk) disable iff (!arstN)
      cslAck |-> cslReq)
      else $error("Console acknowledged without a request");

   ubaAckReq: assert property (@(posedge clk) disable iff (!arstN)
      ubaAck |-> ubaReq)
      else $error("Unibus acknowledged without a request");

   //////////////////////////////
   // Outward request
   //////////////////////////////

   idleQuiet: assert property (@(posedge clk) disable iff (!arstN)
      (state == idle) |-> !cslReqOut)   // Nothing granted, nothing sent
      else $error("Console request out while arbiter idle");

endmodule

// File: test/ks10BusTb.sv
// KS10 bus testbench
`timescale 1ns/1ns

module ks10BusTb
   import ks10Pkg::*;
();

   localparam int cpuId     = 0;
   localparam int cslId     = 1;
   localparam int ubaId     = 2;
   localparam int memWrites = 100;   // Each one read back later
   localparam int ackLimit  = 16;    // Longest wait for one ack
   localparam int maxCycles = 4000;  // Tests run about 1000 cycles

   logic    clk;
   logic    arstN;
   logic    cpuReq;
   logic    cpuAck;
   ks10Addr cpuAddr;
   ks10Word cpuWrData;
   ks10Word cpuRdData;
   logic    cslReq;
   logic    cslAck;
   ks10Addr cslAddr;
   ks10Word cslWrData;
   ks10Word cslRdData;
   logic    ubaReq;
   logic    ubaAck;
   ks10Addr ubaAddr;
   ks10Word ubaWrData;
   ks10Word ubaRdData;
   logic    cslReqOut;
   logic    cslAckIn   = 1'b0;      // Console model drives these
   ks10Word cslTgtData = '0;
   ks10Addr arbAddr;
   ks10Word arbWrData;

   ks10Word refMem  [0:memWords-1];     // Expected memory contents
   ks10Word refRegs [0:ioRegCount-1];   // Expected I/O registers
   memIdx   memUsed [$];                // Indices written so far
   ks10Word cslTable [$];               // Console answer words
   int      cslDelays [$];
   int      cslCount = 0;
   int      cslWait  = 0;
   logic    cslBusy  = 1'b0;
   ks10Word cslWord;                    // Word of the latest console answer
   int      ackCode;                    // Ack order, one digit per master
   int      checks;
   int      errors;
   int      cycleCount;

   tbClock #(.periodNs(8), .resetCycles(8)) clockGen (.clk(clk), .arstN(arstN));

   ks10Bus dut (.*);

   bind ks10Arbiter ks10ArbiterAssert arbChecks (
      .clk       (clk),
      .arstN     (arstN),
      .cpuReq    (cpuReq),
      .cslReq    (cslReq),
      .ubaReq    (ubaReq),
      .cpuAck    (cpuAck),
      .cslAck    (cslAck),
      .ubaAck    (ubaAck),
      .cslReqOut (cslReqOut),
      .state     (state)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic ks10Word randWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[35:0];
   endfunction

   function automatic ks10Addr memAddr(input logic wr, input memIdx idx);
      ks10Addr a;
      a = '0;
      a[addrWriteBit] = wr;
      a[wordBits-memAddrBits +: memAddrBits] = idx;   // Low bits index memory
      return a;
   endfunction

   function automatic ks10Addr ioAddr(input logic wr, input ioDev dev, input ioIdx idx);
      ks10Addr a;
      a = '0;
      a[addrWriteBit]        = wr;
      a[addrIoBit]           = 1'b1;
      a[ioDevMsb:ioDevLsb]   = dev;
      a[wordBits-ioRegBits +: ioRegBits] = idx;
      return a;
   endfunction

   function automatic string masterName(input int m);
      case (m)
         cpuId:   return "cpu";
         cslId:   return "csl";
         default: return "uba";
      endcase
   endfunction

   function automatic logic ackOf(input int m);
      case (m)
         cpuId:   return cpuAck;
         cslId:   return cslAck;
         default: return ubaAck;
      endcase
   endfunction

   function automatic ks10Word rdOf(input int m);
      case (m)
         cpuId:   return cpuRdData;
         cslId:   return cslRdData;
         default: return ubaRdData;
      endcase
   endfunction

   task automatic driveMaster(input int m, input logic req, input ks10Addr a,
                              input ks10Word d);
      case (m)
         cpuId:
         begin
            cpuReq    = req;
            cpuAddr   = a;
            cpuWrData = d;
         end
         cslId:
         begin
            cslReq    = req;
            cslAddr   = a;
            cslWrData = d;
         end
         default:
         begin
            ubaReq    = req;
            ubaAddr   = a;
            ubaWrData = d;
         end
      endcase
   endtask

   task automatic checkWord(input string name, input ks10Word exp, input ks10Word act);
      checks++;
      assert (act === exp)
      else
      begin
         errors++;
         $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic checkIdle();
      checkWord("cpuAck cslAck ubaAck cslReqOut", '0,
                ks10Word'({cpuAck, cslAck, ubaAck, cslReqOut}));
   endtask

   task automatic checkOrder(input int exp);
      checks++;
      assert (ackCode == exp)
      else
      begin
         errors++;
         $display("Masters acknowledged in the wrong order at %0t ns: expected %0d, saw %0d",
                  $time, exp, ackCode);
      end
   endtask

   // Request, wait for ack, drop the request
   task automatic busAccess(input int m, input ks10Addr a, input ks10Word d,
                            input int expLat, output ks10Word rd);
      int   lat;
      logic ack;
      lat = 0;
      ack = 1'b0;
      rd  = '0;
      @(negedge clk);
      driveMaster(m, 1'b1, a, d);
      @(posedge clk);                        // Edge that sees the request
      while (!ack && lat < ackLimit)
      begin
         @(posedge clk);
         lat++;
         ack = ackOf(m);
         if (ack)
            rd = rdOf(m);                    // Read data valid with ack
      end
      if (!ack)
      begin
         errors++;
         $display("No acknowledge for the %s master within %0d cycles at %0t ns",
                  masterName(m), ackLimit, $time);
      end
      else
      begin
         ackCode = ackCode * 10 + m + 1;
         if (expLat > 0)
            checkWord({masterName(m), "Ack latency"}, ks10Word'(expLat), ks10Word'(lat));
      end
      @(negedge clk);
      driveMaster(m, 1'b0, '0, '0);
   endtask

   //////////////////////////////
   // Console target model
   //////////////////////////////

   always @(negedge clk)
   begin
      if (cslAckIn)
         cslAckIn = 1'b0;                    // One-cycle ack
      else if (cslBusy)
      begin
         cslWait--;
         if (cslWait == 0)
         begin
            cslBusy    = 1'b0;
            cslAckIn   = 1'b1;
            cslTgtData = cslWord;
         end
      end
      else if (cslReqOut)
      begin
         checkWord("arbAddr", cpuAddr, arbAddr);   // Only the CPU reaches the console
         checkWord("arbWrData", cpuWrData, arbWrData);
         cslBusy = 1'b1;
         cslWait = cslDelays[cslCount % cslDelays.size()];   // 1 to 5 cycles
         cslWord = cslTable[cslCount % cslTable.size()];
         cslCount++;
      end
   end

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic memTest();
      memIdx   idx;
      ks10Word w;
      ks10Word rd;
      for (int i = 0; i < memWrites; i++)
      begin
         idx = memIdx'($urandom_range(memWords - 1));
         w   = randWord();
         busAccess(cpuId, memAddr(1'b1, idx), w, 2, rd);
         refMem[idx] = w;                    // Last write wins
         memUsed.push_back(idx);
      end
      foreach (memUsed[i])
      begin
         busAccess(cpuId, memAddr(1'b0, memUsed[i]), '0, 2, rd);
         checkWord("cpuRdData", refMem[memUsed[i]], rd);
      end
   endtask

   task automatic priorityTest();
      ks10Word rdCpu;
      ks10Word rdCsl;
      ks10Word rdUba;
      ackCode = 0;
      fork                                   // All three in one cycle
         busAccess(cslId, memAddr(1'b0, memUsed[0]), '0, 2, rdCsl);
         busAccess(ubaId, memAddr(1'b0, memUsed[1]), '0, -1, rdUba);
         busAccess(cpuId, memAddr(1'b0, memUsed[2]), '0, -1, rdCpu);
      join
      checkOrder(231);                       // Console, Unibus, CPU
      checkWord("cslRdData", refMem[memUsed[0]], rdCsl);
      checkWord("ubaRdData", refMem[memUsed[1]], rdUba);
      checkWord("cpuRdData", refMem[memUsed[2]], rdCpu);
      ackCode = 0;
      fork
         busAccess(cpuId, memAddr(1'b0, memUsed[3]), '0, 2, rdCpu);
         begin
            @(negedge clk);                  // Arrives after the CPU grant
            busAccess(cslId, memAddr(1'b0, memUsed[4]), '0, -1, rdCsl);
         end
      join
      checkOrder(12);                        // CPU finishes first
      checkWord("cpuRdData", refMem[memUsed[3]], rdCpu);
      checkWord("cslRdData", refMem[memUsed[4]], rdCsl);
   endtask

   task automatic ubaTest();
      memIdx   idx;
      ks10Word w;
      ks10Word rd;
      for (int i = 0; i < 4; i++)
      begin
         idx = memIdx'($urandom_range(memWords - 1));
         w   = randWord();
         busAccess(ubaId, memAddr(1'b1, idx), w, 2, rd);
         refMem[idx] = w;
         busAccess(cpuId, memAddr(1'b0, idx), '0, 2, rd);
         checkWord("cpuRdData", w, rd);
      end
   endtask

   task automatic ioTest();
      int      m;
      ioIdx    idx;
      ioDev    dev;
      ks10Word w;
      ks10Word rd;
      for (int i = 0; i < 16; i++)
      begin
         m   = (i % 2 == 0) ? cpuId : cslId;
         idx = ioIdx'($urandom_range(ioRegCount - 1));
         dev = ioDev'($urandom_range(15, 1));   // Any device but the console
         w   = randWord();
         busAccess(m, ioAddr(1'b1, dev, idx), w, 2, rd);
         refRegs[idx] = w;
      end
      for (int i = 0; i < ioRegCount; i++)
      begin
         m   = (i % 2 == 0) ? cslId : cpuId;
         idx = ioIdx'(i);
         dev = ioDev'($urandom_range(15, 1));
         busAccess(m, ioAddr(1'b0, dev, idx), '0, 2, rd);
         checkWord({masterName(m), "RdData"}, refRegs[idx], rd);
      end
   endtask

   task automatic cslTargetTest();
      ks10Word rd;
      int      lat;
      for (int i = 0; i < 6; i++)
      begin
         lat = cslDelays[cslCount % cslDelays.size()] + 1;   // Grant cycle plus console delay
         busAccess(cpuId, ioAddr(i % 2 == 1, '0, ioIdx'($urandom_range(ioRegCount - 1))),
                   randWord(), lat, rd);
         checkWord("cpuRdData", cslWord, rd);   // Word the console answered
      end
   endtask

   //////////////////////////////
   // Run control
   //////////////////////////////

   initial
   begin
      cpuReq    = 1'b0;
      cpuAddr   = '0;
      cpuWrData = '0;
      cslReq    = 1'b0;
      cslAddr   = '0;
      cslWrData = '0;
      ubaReq    = 1'b0;
      ubaAddr   = '0;
      ubaWrData = '0;
      checks    = 0;
      errors    = 0;
      ackCode   = 0;
      refRegs   = '{default: '0};            // Registers come up clear
      void'($urandom(62537));
      for (int i = 0; i < 8; i++)
         cslTable.push_back(randWord());
      for (int i = 0; i < 16; i++)
         cslDelays.push_back($urandom_range(5, 1));
      @(posedge clk);
      while (arstN !== 1'b1)
      begin
         @(posedge clk);
         checkIdle();
      end
      repeat (4)
      begin
         @(posedge clk);
         checkIdle();                        // Quiet until the first request
      end
      memTest();
      priorityTest();
      ubaTest();
      ioTest();
      cslTargetTest();
      repeat (2) @(negedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // Run limit
   initial
   begin
      cycleCount = 0;
      while (cycleCount < maxCycles)
      begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout: tests did not finish within %0d cycles", maxCycles);
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: test/tbClock.sv
// Testbench clock and reset
`timescale 1ns/1ns

module tbClock #(
   parameter int periodNs    = 8,
   parameter int resetCycles = 8
) (
   output logic clk,
   output logic arstN
);

   initial
   begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

   // Reset held, then released on a falling edge
   initial
   begin
      arstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
   end

endmodule
